/* tb.f */
source/cnv_pkg.sv
source/scan_if.sv
source/frame_ctrl.sv
source/weight_bank.sv
source/window_fetch.sv
source/conv_mac.sv
source/out_pack.sv
source/cnv_engine.sv
verif/cnv_tb.sv

/* verif/cnv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cnv_tb;

   localparam int IMG_WIDTH   = 8;
   localparam int IMG_HEIGHT  = 6;
   localparam int VSYNC_DELAY = 6;
   localparam int HSYNC_DELAY = 2;
   localparam int N_PIX       = IMG_WIDTH * IMG_HEIGHT;
   localparam int N_ENTRIES   = 7;
   localparam int TIMEOUT_CYC = N_ENTRIES *
                                (4 * N_PIX + VSYNC_DELAY + IMG_HEIGHT * HSYNC_DELAY + 100);

   localparam int IMG_RAND = 0, IMG_ONES = 1, IMG_ZERO = 2, IMG_RAMP = 3;
   localparam int WGT_RAND = 0, WGT_ONES = 1, WGT_CENTRE = 2;
   localparam int BP_NONE  = 0, BP_RAND  = 1, BP_ALT  = 2;

   typedef struct packed {
      int img;                                  // Image pattern
      int wgt;                                  // Kernel weight pattern
      int bp;                                   // Output stall pattern
      int beats;                                // Result beats per frame
   } test_t;

   logic        clk;
   logic        rstn;
   logic        i_wgt_we;
   logic [1:0]  i_wgt_sel;
   logic [71:0] i_wgt_data;
   logic        i_pix_valid;
   logic        o_pix_ready;
   logic [7:0]  i_pix_data;
   logic        i_start;
   logic        o_busy;
   logic        o_res_valid;
   logic        i_res_ready;
   logic [31:0] o_res_data;
   logic        o_res_last;

   test_t       tests [N_ENTRIES];
   logic [7:0]  img [N_PIX];                    // Frame as streamed
   logic [7:0]  wgt [4][9];                     // Taps per kernel, row-major
   logic [31:0] exp_word [N_PIX];               // Model result per pixel
   logic [31:0] rng;
   int          n_checks;
   int          n_errors;

   cnv_engine #(
      .IMG_WIDTH   (IMG_WIDTH),
      .IMG_HEIGHT  (IMG_HEIGHT),
      .VSYNC_DELAY (VSYNC_DELAY),
      .HSYNC_DELAY (HSYNC_DELAY)
   ) dut_i (
      .clk         (clk),
      .rstn        (rstn),
      .i_wgt_we    (i_wgt_we),
      .i_wgt_sel   (i_wgt_sel),
      .i_wgt_data  (i_wgt_data),
      .i_pix_valid (i_pix_valid),
      .o_pix_ready (o_pix_ready),
      .i_pix_data  (i_pix_data),
      .i_start     (i_start),
      .o_busy      (o_busy),
      .o_res_valid (o_res_valid),
      .i_res_ready (i_res_ready),
      .o_res_data  (o_res_data),
      .o_res_last  (o_res_last)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                    // 4 ns period
   end

   // -------------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic test_t make_entry(input int img_m, input int wgt_m, input int bp_m);
      test_t e;
      e.img   = img_m;
      e.wgt   = wgt_m;
      e.bp    = bp_m;
      e.beats = N_PIX;                          // One beat per pixel
      return e;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      end
   endtask

   // Sum of nine weight times neighbor products, zero outside the frame
   function automatic logic [7:0] conv_ref(input int k, input int r, input int c);
      int acc;
      int rr;
      int cc;
      acc = 0;
      for (int t = 0; t < 9; t++) begin
         rr = r + t / 3 - 1;
         cc = c + t % 3 - 1;
         if (rr >= 0 && rr < IMG_HEIGHT && cc >= 0 && cc < IMG_WIDTH) begin
            acc += int'(img[rr * IMG_WIDTH + cc]) * int'(wgt[k][t]);
         end
      end
      return 8'((acc >> 12) & 255);             // Keep bits 19..12
   endfunction

   task automatic build_stimulus(input test_t e);
      int n;
      int pad;
      logic [7:0] b;
      for (int p = 0; p < N_PIX; p++) begin
         rng = xorshift32(rng);
         case (e.img)
            IMG_RAND: img[p] = rng[7:0];
            IMG_ONES: img[p] = 8'hff;
            IMG_ZERO: img[p] = 8'h00;
            default:  img[p] = 8'((p * 5) & 255); // Ramp
         endcase
      end
      for (int k = 0; k < 4; k++) begin
         for (int t = 0; t < 9; t++) begin
            rng = xorshift32(rng);
            case (e.wgt)
               WGT_RAND: wgt[k][t] = rng[15:8];
               WGT_ONES: wgt[k][t] = 8'hff;
               default:  wgt[k][t] = (t == 4) ? 8'hff : 8'h00; // Centre tap only
            endcase
         end
      end
      for (int r = 0; r < IMG_HEIGHT; r++) begin
         for (int c = 0; c < IMG_WIDTH; c++) begin
            for (int k = 0; k < 4; k++) begin
               b = conv_ref(k, r, c);
               if (e.img == IMG_ONES && e.wgt == WGT_ONES) begin
                  n   = (3 - (r == 0) - (r == IMG_HEIGHT - 1)) *
                        (3 - (c == 0) - (c == IMG_WIDTH - 1));
                  pad = (n == 9) ? 142 : (n == 6) ? 95 : 63;
                  b   = 8'(pad);                // Interior, edge or corner count
               end
               exp_word[r * IMG_WIDTH + c][k*8 +: 8] = b;
            end
         end
      end
   endtask

   // -------------------------------------------------------------------------
   // Bus drivers, entered and left 1 ns after a rising edge
   // -------------------------------------------------------------------------
   task automatic write_weights();
      for (int k = 0; k < 4; k++) begin
         i_wgt_we  = 1'b1;
         i_wgt_sel = 2'(k);
         for (int t = 0; t < 9; t++) begin
            i_wgt_data[t*8 +: 8] = wgt[k][t]; // Tap t in byte t
         end
         @(posedge clk);
         #1;
      end
      i_wgt_we = 1'b0;
   endtask

   task automatic stream_frame();
      int p;
      p = 0;
      while (p < N_PIX) begin
         i_pix_valid = 1'b1;
         i_pix_data  = img[p];
         @(posedge clk);
         if (o_pix_ready) begin
            p++;                                // Pixel taken at this edge
         end
         #1;
      end
      i_pix_valid = 1'b0;
   endtask

   task automatic start_frame();
      i_start = 1'b1;
      @(posedge clk);
      #1;
      i_start = 1'b0;
   endtask

   task automatic collect_results(input test_t e);
      int          beat;
      bit          done;
      bit          hold;
      bit          toggle;
      logic [31:0] hdata;
      logic        hlast;
      beat   = 0;
      done   = 1'b0;
      hold   = 1'b0;
      toggle = 1'b0;
      while (!done) begin
         case (e.bp)
            BP_NONE: i_res_ready = 1'b1;
            BP_RAND: begin
               rng         = xorshift32(rng);
               i_res_ready = rng[3];
            end
            default: begin
               i_res_ready = toggle;
               toggle      = !toggle;
            end
         endcase
         @(posedge clk);
         if (hold) begin                        // Stalled beat must not move
            check_value(o_res_valid, 1'b1, "valid dropped under stall");
            check_value(o_res_data, hdata, "data changed under stall");
            check_value(o_res_last, hlast, "last changed under stall");
         end
         if (o_res_valid && i_res_ready) begin
            if (beat < N_PIX) begin
               check_value(o_res_data, exp_word[beat], $sformatf("result pixel %0d", beat));
            end
            check_value(o_res_last, beat == N_PIX - 1, $sformatf("last on beat %0d", beat));
            beat++;
            done = o_res_last;
         end
         hold  = o_res_valid && !i_res_ready;
         hdata = o_res_data;
         hlast = o_res_last;
         #1;
      end
      i_res_ready = 1'b0;
      check_value(beat, e.beats, "result beat count");
      check_value(o_busy, 1'b0, "busy after frame");
   endtask

   // Pixel input closes for the whole scan
   always @(posedge clk) begin
      if (rstn && o_busy) begin
         check_value(o_pix_ready, 1'b0, "pixel ready while busy");
      end
   end

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------
   initial begin
      rstn        = 1'b0;
      i_wgt_we    = 1'b0;
      i_wgt_sel   = '0;
      i_wgt_data  = '0;
      i_pix_valid = 1'b0;
      i_pix_data  = '0;
      i_start     = 1'b0;
      i_res_ready = 1'b0;
      rng         = 32'h8dc;
      n_checks    = 0;
      n_errors    = 0;
      tests[0] = make_entry(IMG_RAND, WGT_RAND,   BP_NONE);
      tests[1] = make_entry(IMG_RAMP, WGT_CENTRE, BP_NONE);
      tests[2] = make_entry(IMG_ONES, WGT_ONES,   BP_NONE);
      tests[3] = make_entry(IMG_RAND, WGT_RAND,   BP_RAND);
      tests[4] = make_entry(IMG_RAND, WGT_RAND,   BP_ALT);
      tests[5] = make_entry(IMG_ZERO, WGT_RAND,   BP_RAND);
      tests[6] = make_entry(IMG_RAMP, WGT_RAND,   BP_ALT);
      repeat (10) @(posedge clk);
      #1;
      rstn = 1'b1;
      check_value(o_res_valid, 1'b0, "valid after reset");
      check_value(o_res_last, 1'b0, "last after reset");
      check_value(o_busy, 1'b0, "busy after reset");
      check_value(o_pix_ready, 1'b1, "pixel ready after reset");
      for (int i = 0; i < N_ENTRIES; i++) begin
         build_stimulus(tests[i]);
         write_weights();                       // New kernels every frame
         stream_frame();
         start_frame();
         collect_results(tests[i]);
      end
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("Run timed out after %0d cycles, errors so far: %0d", TIMEOUT_CYC, n_errors);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* source/cnv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module cnv_engine #(
   parameter int IMG_WIDTH   = 8,
   parameter int IMG_HEIGHT  = 6,
   parameter int VSYNC_DELAY = 6,
   parameter int HSYNC_DELAY = 2
) (
   input  logic                                        clk,
   input  logic                                        rstn,
   input  logic                                        i_wgt_we,
   input  logic [cnv_pkg::KSEL_W-1:0]                  i_wgt_sel,
   input  logic [cnv_pkg::N_TAPS*cnv_pkg::PIX_W-1:0]   i_wgt_data,
   input  logic                                        i_pix_valid,
   output logic                                        o_pix_ready,
   input  logic [cnv_pkg::PIX_W-1:0]                   i_pix_data,
   input  logic                                        i_start,
   output logic                                        o_busy,
   output logic                                        o_res_valid,
   input  logic                                        i_res_ready,
   output logic [cnv_pkg::OUT_W-1:0]                   o_res_data,
   output logic                                        o_res_last
);

   localparam int ROW_W = $clog2(IMG_HEIGHT);
   localparam int COL_W = $clog2(IMG_WIDTH);

   logic                       wl_en;
   logic [cnv_pkg::KSEL_W-1:0] wl_sel;
   cnv_pkg::tap_word_u         weights [cnv_pkg::N_KERNELS];
   logic                       win_valid;
   logic                       win_last;
   cnv_pkg::tap_word_u         win;
   cnv_pkg::acc_t              acc [cnv_pkg::N_KERNELS];
   logic                       mac_valid;       // Kernel 0 speaks for all
   logic                       mac_last;
   logic                       advance;

   scan_if #(.ROW_W(ROW_W), .COL_W(COL_W)) scan_bus ();

   // -------------------------------------------------------------------------
   // Control and operand supply
   // -------------------------------------------------------------------------
   frame_ctrl #(
      .IMG_WIDTH   (IMG_WIDTH),
      .IMG_HEIGHT  (IMG_HEIGHT),
      .VSYNC_DELAY (VSYNC_DELAY),
      .HSYNC_DELAY (HSYNC_DELAY)
   ) u_ctrl (
      .clk      (clk),
      .rstn     (rstn),
      .i_start  (i_start),
      .o_busy   (o_busy),
      .o_wl_en  (wl_en),
      .o_wl_sel (wl_sel),
      .scan     (scan_bus.master)
   );

   weight_bank u_wbank (
      .clk        (clk),
      .rstn       (rstn),
      .i_wgt_we   (i_wgt_we),
      .i_wgt_sel  (i_wgt_sel),
      .i_wgt_data (i_wgt_data),
      .i_wl_en    (wl_en),
      .i_wl_sel   (wl_sel),
      .o_weights  (weights)
   );

   window_fetch #(
      .IMG_WIDTH  (IMG_WIDTH),
      .IMG_HEIGHT (IMG_HEIGHT)
   ) u_fetch (
      .clk         (clk),
      .rstn        (rstn),
      .i_pix_valid (i_pix_valid),
      .o_pix_ready (o_pix_ready),
      .i_pix_data  (i_pix_data),
      .i_start     (i_start),
      .i_busy      (o_busy),
      .i_advance   (advance),
      .scan        (scan_bus.slave),
      .o_win_valid (win_valid),
      .o_win_last  (win_last),
      .o_win       (win)
   );

   // -------------------------------------------------------------------------
   // MAC kernels
   // -------------------------------------------------------------------------
   for (genvar k = 0; k < cnv_pkg::N_KERNELS; k++) begin : g_mac
      if (k == 0) begin : g_lead
         conv_mac u_mac (
            .clk (clk), .rstn (rstn), .i_advance (advance),
            .i_valid (win_valid), .i_last (win_last),
            .i_win (win), .i_weight (weights[k]),
            .o_valid (mac_valid), .o_last (mac_last), .o_acc (acc[k])
         );
      end else begin : g_follow                  // Lockstep with kernel 0
         conv_mac u_mac (
            .clk (clk), .rstn (rstn), .i_advance (advance),
            .i_valid (win_valid), .i_last (win_last),
            .i_win (win), .i_weight (weights[k]),
            .o_valid (), .o_last (), .o_acc (acc[k])
         );
      end
   end

   out_pack #(
      .IMG_WIDTH  (IMG_WIDTH),
      .IMG_HEIGHT (IMG_HEIGHT)
   ) u_pack (
      .clk         (clk),
      .rstn        (rstn),
      .i_valid     (mac_valid),
      .i_last      (mac_last),
      .i_acc       (acc),
      .i_res_ready (i_res_ready),
      .o_res_valid (o_res_valid),
      .o_res_data  (o_res_data),
      .o_res_last  (o_res_last),
      .o_advance   (advance)
   );

endmodule

`default_nettype wire

/* source/out_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module out_pack #(
   parameter int IMG_WIDTH  = 8,
   parameter int IMG_HEIGHT = 6
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      i_valid,
   input  logic                      i_last,
   input  cnv_pkg::acc_t             i_acc [cnv_pkg::N_KERNELS],
   input  logic                      i_res_ready,
   output logic                      o_res_valid,
   output logic [cnv_pkg::OUT_W-1:0] o_res_data,
   output logic                      o_res_last,
   output logic                      o_advance
);

   localparam int N_PIX = IMG_WIDTH * IMG_HEIGHT;
   localparam int CNT_W = $clog2(N_PIX);

   logic [cnv_pkg::OUT_W-1:0] res_d;
   logic [CNT_W-1:0]          pix_cnt;          // Pixels taken this frame
   logic                      take;

   // Whole pipeline stalls only on a held result
   assign o_advance = !(o_res_valid && !i_res_ready);
   assign take      = i_valid && o_advance;

   // Kernel k lands in byte k
   always_comb begin
      for (int k = 0; k < cnv_pkg::N_KERNELS; k++) begin
         res_d[k*cnv_pkg::PIX_W +: cnv_pkg::PIX_W] = i_acc[k][cnv_pkg::Q_MSB:cnv_pkg::Q_LSB];
      end
   end

   // -------------------------------------------------------------------------
   // Output register
   // -------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_res_valid <= 1'b0;
         o_res_last  <= 1'b0;
         pix_cnt     <= '0;
      end else if (o_advance) begin
         o_res_valid <= i_valid;
         o_res_last  <= i_valid && i_last;
         if (i_valid) begin
            pix_cnt <= i_last ? '0 : pix_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         o_res_data <= res_d;                    // Held under back-pressure
      end
   end

   // End flag from the scan lines up with the pixel count
   a_last_on_count : assert property (@(posedge clk) disable iff (!rstn)
      take |-> (i_last == (pix_cnt == CNT_W'(N_PIX - 1))));

endmodule

`default_nettype wire

/* source/conv_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
   input  logic               clk,
   input  logic               rstn,
   input  logic               i_advance,
   input  logic               i_valid,
   input  logic               i_last,
   input  cnv_pkg::tap_word_u i_win,
   input  cnv_pkg::tap_word_u i_weight,
   output logic               o_valid,
   output logic               o_last,
   output cnv_pkg::acc_t      o_acc
);

   localparam int PROD_W = 2 * cnv_pkg::PIX_W;

   logic [PROD_W-1:0] prod_q [cnv_pkg::N_TAPS]; // Stage 1 products
   logic              valid_q;
   logic              last_q;
   cnv_pkg::acc_t     sum_d;

   // -------------------------------------------------------------------------
   // Stage 1 multipliers
   // -------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_advance) begin
         for (int t = 0; t < cnv_pkg::N_TAPS; t++) begin
            prod_q[t] <= i_win.tap[t] * i_weight.tap[t]; // Unsigned 8x8
         end
      end
   end

   // Nine 16-bit terms never overflow 20 bits
   always_comb begin
      sum_d = '0;
      for (int t = 0; t < cnv_pkg::N_TAPS; t++) begin
         sum_d += cnv_pkg::acc_t'(prod_q[t]);
      end
   end

   // -------------------------------------------------------------------------
   // Stage 2 adder tree and flags
   // -------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         valid_q <= 1'b0;
         last_q  <= 1'b0;
         o_valid <= 1'b0;
         o_last  <= 1'b0;
      end else if (i_advance) begin
         valid_q <= i_valid;
         last_q  <= i_last;
         o_valid <= valid_q;
         o_last  <= last_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_advance) begin
         o_acc <= sum_d;
      end
   end

endmodule

`default_nettype wire

/* source/window_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module window_fetch #(
   parameter int IMG_WIDTH  = 8,
   parameter int IMG_HEIGHT = 6
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      i_pix_valid,
   output logic                      o_pix_ready,
   input  logic [cnv_pkg::PIX_W-1:0] i_pix_data,
   input  logic                      i_start,
   input  logic                      i_busy,
   input  logic                      i_advance,
   scan_if.slave                     scan,
   output logic                      o_win_valid,
   output logic                      o_win_last,
   output cnv_pkg::tap_word_u        o_win
);

   localparam int N_PIX  = IMG_WIDTH * IMG_HEIGHT;
   localparam int ADDR_W = $clog2(N_PIX);
   localparam int WIN    = 3;                   // Window edge

   logic [cnv_pkg::PIX_W-1:0] fmem [N_PIX];     // Frame memory
   logic [ADDR_W-1:0]         wr_addr;
   logic                      pix_we;
   cnv_pkg::tap_word_u        win_d;

   // -------------------------------------------------------------------------
   // Pixel stream into frame memory
   // -------------------------------------------------------------------------
   assign o_pix_ready = !i_busy;                // Frozen during a scan
   assign pix_we      = i_pix_valid && o_pix_ready;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         wr_addr <= '0;
      end else if (i_start && !i_busy) begin
         wr_addr <= '0;                          // Next frame starts at zero
      end else if (pix_we) begin
         wr_addr <= (wr_addr == ADDR_W'(N_PIX - 1)) ? '0 : wr_addr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (pix_we) begin
         fmem[wr_addr] <= i_pix_data;
      end
   end

   // -------------------------------------------------------------------------
   // Padded 3x3 window
   // -------------------------------------------------------------------------
   always_comb begin
      int r;
      int c;
      win_d = '0;                                // Outside the frame reads zero
      for (int t = 0; t < cnv_pkg::N_TAPS; t++) begin
         r = int'(scan.row) + t / WIN - 1;
         c = int'(scan.col) + t % WIN - 1;
         if (r >= 0 && r < IMG_HEIGHT && c >= 0 && c < IMG_WIDTH) begin
            win_d.tap[t] = fmem[r * IMG_WIDTH + c];
         end
      end
   end

   assign scan.ready = i_advance;               // Beat taken when pipeline moves

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_win_valid <= 1'b0;
         o_win_last  <= 1'b0;
      end else if (i_advance) begin
         o_win_valid <= scan.valid;
         o_win_last  <= scan.valid && scan.last;
      end
   end

   always_ff @(posedge clk) begin
      if (i_advance && scan.valid) begin
         o_win <= win_d;                         // Payload, no reset
      end
   end

   // Frame memory stays untouched for the whole scan
   a_no_wr_busy : assert property (@(posedge clk) disable iff (!rstn)
      i_busy |=> (wr_addr == $past(wr_addr)));

endmodule

`default_nettype wire

/* source/weight_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_bank (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       i_wgt_we,
   input  logic [cnv_pkg::KSEL_W-1:0] i_wgt_sel,
   input  cnv_pkg::tap_word_u         i_wgt_data,
   input  logic                       i_wl_en,
   input  logic [cnv_pkg::KSEL_W-1:0] i_wl_sel,
   output cnv_pkg::tap_word_u         o_weights [cnv_pkg::N_KERNELS]
);

   cnv_pkg::tap_word_u         wmem [cnv_pkg::N_KERNELS]; // Weight buffer
   cnv_pkg::tap_word_u         rd_q;                      // Registered read word
   logic                       ld_en_q;                   // Strobe aligned to rd_q
   logic [cnv_pkg::KSEL_W-1:0] ld_sel_q;                  // Target kernel

   // -------------------------------------------------------------------------
   // Weight memory
   // -------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_wgt_we) begin
         wmem[i_wgt_sel] <= i_wgt_data;          // Host side, only while idle
      end
      if (i_wl_en) begin
         rd_q <= wmem[i_wl_sel];                 // One cycle read
      end
   end

   // Strobe and address follow the read by one stage
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         ld_en_q  <= 1'b0;
         ld_sel_q <= '0;
      end else begin
         ld_en_q  <= i_wl_en;
         ld_sel_q <= i_wl_sel;
      end
   end

   // -------------------------------------------------------------------------
   // Per-kernel registers
   // -------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_weights <= '{default: '0};
      end else if (ld_en_q) begin
         o_weights[ld_sel_q] <= rd_q;            // Valid two cycles after strobe
      end
   end

   // Host writes and the vsync load never collide
   a_no_wr_during_load : assert property (@(posedge clk) disable iff (!rstn)
      i_wl_en |-> !i_wgt_we);

endmodule

`default_nettype wire

/* source/frame_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl #(
   parameter int IMG_WIDTH   = 8,
   parameter int IMG_HEIGHT  = 6,
   parameter int VSYNC_DELAY = 6,
   parameter int HSYNC_DELAY = 2
) (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       i_start,
   output logic                       o_busy,
   output logic                       o_wl_en,
   output logic [cnv_pkg::KSEL_W-1:0] o_wl_sel,
   scan_if.master                     scan
);

   localparam int ROW_W   = $clog2(IMG_HEIGHT);
   localparam int COL_W   = $clog2(IMG_WIDTH);
   localparam int MAX_DLY = (VSYNC_DELAY > HSYNC_DELAY) ? VSYNC_DELAY : HSYNC_DELAY;
   localparam int DLY_W   = ($clog2(MAX_DLY) > cnv_pkg::KSEL_W) ? $clog2(MAX_DLY)
                                                                : cnv_pkg::KSEL_W;

   localparam logic [1:0] S_IDLE  = 2'd0;       // Waiting for start
   localparam logic [1:0] S_VSYNC = 2'd1;       // Frame preamble and weight load
   localparam logic [1:0] S_HSYNC = 2'd2;       // Gap before each row
   localparam logic [1:0] S_DATA  = 2'd3;       // One beat per column

   logic [1:0]       state;
   logic [DLY_W-1:0] dly_cnt;                   // Times both sync phases
   logic [ROW_W-1:0] row_cnt;
   logic [COL_W-1:0] col_cnt;
   logic             end_row;
   logic             end_frame;

   assign end_row   = (col_cnt == COL_W'(IMG_WIDTH - 1));
   assign end_frame = end_row && (row_cnt == ROW_W'(IMG_HEIGHT - 1));

   // -------------------------------------------------------------------------
   // Scan FSM
   // -------------------------------------------------------------------------
   // Everything past idle freezes while the output stage stalls
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state   <= S_IDLE;
         dly_cnt <= '0;
         row_cnt <= '0;
         col_cnt <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (i_start) begin                // Only accepted here
                  state   <= S_VSYNC;
                  dly_cnt <= '0;
                  row_cnt <= '0;
                  col_cnt <= '0;
               end
            end
            S_VSYNC: begin
               if (scan.ready) begin
                  if (dly_cnt == DLY_W'(VSYNC_DELAY - 1)) begin
                     state   <= S_HSYNC;
                     dly_cnt <= '0;
                  end else begin
                     dly_cnt <= dly_cnt + 1'b1;
                  end
               end
            end
            S_HSYNC: begin
               if (scan.ready) begin
                  if (dly_cnt == DLY_W'(HSYNC_DELAY - 1)) begin
                     state   <= S_DATA;
                     dly_cnt <= '0;
                  end else begin
                     dly_cnt <= dly_cnt + 1'b1;
                  end
               end
            end
            default: begin                       // S_DATA, valid always high
               if (scan.ready) begin
                  if (end_frame) begin
                     state   <= S_IDLE;
                     col_cnt <= '0;
                  end else if (end_row) begin
                     state   <= S_HSYNC;
                     col_cnt <= '0;
                     row_cnt <= row_cnt + 1'b1;
                  end else begin
                     col_cnt <= col_cnt + 1'b1;
                  end
               end
            end
         endcase
      end
   end

   assign o_busy   = (state != S_IDLE);
   // First N_KERNELS vsync cycles fetch one kernel word each
   assign o_wl_en  = (state == S_VSYNC) && (int'(dly_cnt) < cnv_pkg::N_KERNELS);
   assign o_wl_sel = dly_cnt[cnv_pkg::KSEL_W-1:0];

   assign scan.valid = (state == S_DATA);
   assign scan.row   = row_cnt;
   assign scan.col   = col_cnt;
   assign scan.last  = (state == S_DATA) && end_frame;

   // A start pulse mid-frame must not restart the preamble
   a_start_busy : assert property (@(posedge clk) disable iff (!rstn)
      (i_start && o_busy) |=> !(state == S_VSYNC && dly_cnt == '0)
                              || $past(state == S_VSYNC && dly_cnt == '0));

endmodule

`default_nettype wire

/* source/scan_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Scan beats from the frame controller to the window fetch
interface scan_if #(
   parameter int ROW_W = 3,
   parameter int COL_W = 3
);
   logic             valid;                     // Beat present
   logic             ready;                     // Pipeline advance
   logic [ROW_W-1:0] row;                       // Pixel row
   logic [COL_W-1:0] col;                       // Pixel column
   logic             last;                      // Final pixel of frame

   modport master (
      output valid,
      output row,
      output col,
      output last,
      input  ready
   );

   modport slave (
      input  valid,
      input  row,
      input  col,
      input  last,
      output ready
   );
endinterface

`default_nettype wire

/* source/cnv_pkg.sv */
`default_nettype none

package cnv_pkg;

   // -------------------------------------------------------------------------
   // Datapath widths and counts
   // -------------------------------------------------------------------------
   localparam int PIX_W     = 8;                 // Activation and weight width
   localparam int N_TAPS    = 9;                 // 3x3 window
   localparam int N_KERNELS = 4;                 // Kernels run in lockstep
   localparam int ACC_W     = 20;                // Holds nine 8x8 products
   localparam int Q_MSB     = 19;                // Top of kept slice
   localparam int Q_LSB     = 12;                // Bottom of kept slice
   localparam int OUT_W     = N_KERNELS * PIX_W; // One byte per kernel
   localparam int KSEL_W    = 2;                 // Kernel index width

   // -------------------------------------------------------------------------
   // Tap word
   // -------------------------------------------------------------------------
   // Moves as one flat word, read back as nine taps in row-major order.
   // Tap 0 is the top-left neighbor and tap 8 the bottom-right one.
   typedef union packed {
      logic [N_TAPS*PIX_W-1:0]      flat;       // Bus and memory view
      logic [N_TAPS-1:0][PIX_W-1:0] tap;        // Per-tap view for the MAC
   } tap_word_u;

   typedef logic [ACC_W-1:0] acc_t;             // Unsigned MAC sum

endpackage

`default_nettype wire
